// ==== Makefile ====
TOP = upd_periph_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// ==== project.f ====
rtl/upd_periph_pkg.sv
rtl/upd_sfr_bus.sv
rtl/upd_ports.sv
rtl/upd_timer.sv
rtl/upd_intc.sv
rtl/upd_periph.sv
sim/upd_periph_props.sv
sim/upd_periph_tb.sv

// ==== rtl/upd_intc.sv ====
module upd_intc (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic [upd_periph_pkg::SFR_W-1:0] sfr_wdata,
  input  logic                             wr_mk,
  input  logic                             wr_ie,
  input  logic                             wr_iack,
  input  logic                             tc_uf,
  input  logic                             int0,
  input  logic                             int1,
  input  logic                             int2,
  output logic [upd_periph_pkg::SFR_W-1:0] mk_q,
  output logic                             ie_q,
  output logic [upd_periph_pkg::SFR_W-1:0] vector,
  output logic                             irq
);
  import upd_periph_pkg::*;

  logic [SFR_W-1:0] mk;
  logic             ie;
  logic [3:0]       int1_hist, int2_hist;
  logic [N_IRQ-1:0] pend, pend_set, pend_clr;
  logic [N_IRQ-1:0] enabled, win;

  always_ff @(posedge CLK) begin
    if (reset) begin
      mk <= MK_RESET;
      ie <= 1'b0;
    end else begin
      if (wr_mk) mk <= sfr_wdata;
      if (wr_ie) ie <= sfr_wdata[0];
    end
  end

  ////////////////////////////////////////
  // Edge filter for INT1 and INT2

  // A request needs three high samples after a low one.
  // Histories start all high so a pin held high at reset is ignored.
  always_ff @(posedge CLK) begin
    if (reset) begin
      int1_hist <= '1;
      int2_hist <= '1;
    end else begin
      int1_hist <= {int1_hist[2:0], int1};
      int2_hist <= {int2_hist[2:0], int2 ^ ~mk[MK_INT2_POL]};
    end
  end

  ////////////////////////////////////////
  // Pending flags

  always_comb begin
    pend_set          = '0;
    pend_set[II_INT0] = int0;
    pend_set[II_INTT] = tc_uf;
    pend_set[II_INT1] = (int1_hist == 4'b0111);
    pend_set[II_INT2] = (int2_hist == 4'b0111);
  end

  // INT0 is a level, so it drops with the pin and returns after ack
  always_comb begin
    pend_clr          = win & {N_IRQ{wr_iack}};
    pend_clr[II_INT0] = pend_clr[II_INT0] | ~int0;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~pend_clr) | pend_set;
    end
  end

  ////////////////////////////////////////
  // Mask, priority and vector

  assign enabled = pend & ~mk[N_IRQ-1:0] & {N_IRQ{ie}};
  // Isolate lowest set bit
  assign win     = enabled & (~enabled + 1'b1);
  assign irq     = |enabled;

  always_comb begin
    case (1'b1)
      win[II_INT0]: vector = VEC_INT0;
      win[II_INTT]: vector = VEC_INTT;
      win[II_INT1]: vector = VEC_INT1;
      win[II_INT2]: vector = VEC_INT2;
      default:      vector = VEC_NONE;
    endcase
  end

  assign mk_q = mk;
  assign ie_q = ie;

endmodule

// ==== rtl/upd_periph.sv ====
module upd_periph (
  input  logic                                  CLK,
  input  logic                                  reset,
  input  logic [upd_periph_pkg::AXI_ADDR_W-1:0] awaddr,
  input  logic                                  awvalid,
  output logic                                  awready,
  input  logic [upd_periph_pkg::AXI_DATA_W-1:0] wdata,
  input  logic [upd_periph_pkg::AXI_DATA_W/8-1:0] wstrb,
  input  logic                                  wvalid,
  output logic                                  wready,
  output logic                                  bvalid,
  output logic [1:0]                            bresp,
  input  logic                                  bready,
  input  logic [upd_periph_pkg::AXI_ADDR_W-1:0] araddr,
  input  logic                                  arvalid,
  output logic                                  arready,
  output logic                                  rvalid,
  output logic [upd_periph_pkg::AXI_DATA_W-1:0] rdata,
  output logic [1:0]                            rresp,
  input  logic                                  rready,
  input  logic [upd_periph_pkg::SFR_W-1:0]      pb_i,
  input  logic [upd_periph_pkg::SFR_W-1:0]      pc_i,
  input  logic                                  int0,
  input  logic                                  int1,
  input  logic                                  int2,
  output logic [upd_periph_pkg::SFR_W-1:0]      pa_o,
  output logic [upd_periph_pkg::SFR_W-1:0]      pb_o,
  output logic [upd_periph_pkg::SFR_W-1:0]      pb_oe,
  output logic [upd_periph_pkg::SFR_W-1:0]      pc_o,
  output logic [upd_periph_pkg::SFR_W-1:0]      pc_oe,
  output logic                                  irq
);
  import upd_periph_pkg::*;

  logic [SFR_W-1:0] sfr_wdata;
  logic wr_pa, wr_pb, wr_pc, wr_mk, wr_mb, wr_mc;
  logic wr_tm0, wr_tm1, wr_ie, wr_stm, wr_iack;
  logic [SFR_W-1:0] pa_q, pb_rd, pc_rd, mk_q, mb_q, mc_q, vector;
  logic [TM_W-1:0]  tm_q;
  logic             ie_q;
  logic             tc_uf;

  // Register bus
  upd_sfr_bus upd_sfr_bus_i (.*);

  upd_ports upd_ports_i (.*);

  upd_timer upd_timer_i (.*);

  // Interrupts take the timer underflow
  upd_intc upd_intc_i (.*);

endmodule

// ==== rtl/upd_periph_pkg.sv ====
package upd_periph_pkg;

  // Bus and register widths
  localparam int AXI_ADDR_W = 6;
  localparam int AXI_DATA_W = 32;
  localparam int SFR_W      = 8;
  localparam int TM_W       = 12;
  localparam int PRESCALE_W = 3;

  // Register byte offsets
  localparam logic [AXI_ADDR_W-1:0] SFR_PA   = 6'h00;
  localparam logic [AXI_ADDR_W-1:0] SFR_PB   = 6'h04;
  localparam logic [AXI_ADDR_W-1:0] SFR_PC   = 6'h08;
  localparam logic [AXI_ADDR_W-1:0] SFR_MK   = 6'h0C;
  localparam logic [AXI_ADDR_W-1:0] SFR_MB   = 6'h10;
  localparam logic [AXI_ADDR_W-1:0] SFR_MC   = 6'h14;
  localparam logic [AXI_ADDR_W-1:0] SFR_TM0  = 6'h18;
  localparam logic [AXI_ADDR_W-1:0] SFR_TM1  = 6'h1C;
  localparam logic [AXI_ADDR_W-1:0] SFR_IE   = 6'h20;
  localparam logic [AXI_ADDR_W-1:0] SFR_STM  = 6'h24;
  localparam logic [AXI_ADDR_W-1:0] SFR_IACK = 6'h28;

  // AXI response codes
  localparam logic [1:0] AXI_RESP_OKAY   = 2'd0;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'd2;

  // Interrupt sources, lowest index wins
  localparam int II_INT0 = 0;
  localparam int II_INTT = 1;
  localparam int II_INT1 = 2;
  localparam int II_INT2 = 3;
  localparam int N_IRQ   = 4;

  localparam logic [SFR_W-1:0] VEC_INT0 = 8'h04;
  localparam logic [SFR_W-1:0] VEC_INTT = 8'h08;
  localparam logic [SFR_W-1:0] VEC_INT1 = 8'h10;
  localparam logic [SFR_W-1:0] VEC_INT2 = 8'h20;
  localparam logic [SFR_W-1:0] VEC_NONE = 8'h00;

  // Reset values
  localparam logic [SFR_W-1:0] MK_RESET = 8'hFF;
  localparam logic [SFR_W-1:0] MB_RESET = 8'hFF;
  localparam logic [SFR_W-1:0] MC_RESET = 8'hFF;
  localparam logic [TM_W-1:0]  TM_RESET = 12'hFFF;
  localparam int               MK_INT2_POL = 5;

  // Port C pins that are outputs regardless of MC
  localparam logic [SFR_W-1:0] PC_FIXED_OE = 8'h78;

endpackage

// ==== rtl/upd_ports.sv ====
module upd_ports (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic [upd_periph_pkg::SFR_W-1:0] sfr_wdata,
  input  logic                             wr_pa,
  input  logic                             wr_pb,
  input  logic                             wr_pc,
  input  logic                             wr_mb,
  input  logic                             wr_mc,
  input  logic [upd_periph_pkg::SFR_W-1:0] pb_i,
  input  logic [upd_periph_pkg::SFR_W-1:0] pc_i,
  output logic [upd_periph_pkg::SFR_W-1:0] pa_o,
  output logic [upd_periph_pkg::SFR_W-1:0] pb_o,
  output logic [upd_periph_pkg::SFR_W-1:0] pb_oe,
  output logic [upd_periph_pkg::SFR_W-1:0] pc_o,
  output logic [upd_periph_pkg::SFR_W-1:0] pc_oe,
  output logic [upd_periph_pkg::SFR_W-1:0] pa_q,
  output logic [upd_periph_pkg::SFR_W-1:0] pb_rd,
  output logic [upd_periph_pkg::SFR_W-1:0] pc_rd,
  output logic [upd_periph_pkg::SFR_W-1:0] mb_q,
  output logic [upd_periph_pkg::SFR_W-1:0] mc_q
);
  import upd_periph_pkg::*;

  logic [SFR_W-1:0] pao, pbo, pco;
  logic [SFR_W-1:0] mb, mc;

  // Output latches and mode registers
  always_ff @(posedge CLK) begin
    if (reset) begin
      pao <= '0;
      pbo <= '0;
      pco <= '0;
      mb  <= MB_RESET;
      mc  <= MC_RESET;
    end else begin
      if (wr_pa) pao <= sfr_wdata;
      if (wr_pb) pbo <= sfr_wdata;
      if (wr_pc) pco <= sfr_wdata;
      if (wr_mb) mb <= sfr_wdata;
      if (wr_mc) mc <= sfr_wdata;
    end
  end

  // MB bit set means input
  assign pb_oe = ~mb;
  // Only PC7, PC1 and PC0 follow MC
  assign pc_oe = PC_FIXED_OE | {~mc[7], 5'b00000, ~mc[1:0]};

  assign pa_o = pao;
  assign pb_o = pbo;
  // Control-function pins masked by MC
  assign pc_o = pco & {mc[7:2], ~mc[1:0]};

  // Pin state for inputs, latch for outputs
  assign pb_rd = (pb_i & ~pb_oe) | (pbo & pb_oe);
  assign pc_rd = (pc_i & ~pc_oe) | (pco & pc_oe);

  assign pa_q = pao;
  assign mb_q = mb;
  assign mc_q = mc;

endmodule

// ==== rtl/upd_sfr_bus.sv ====
module upd_sfr_bus (
  input  logic                                CLK,
  input  logic                                reset,
  input  logic [upd_periph_pkg::AXI_ADDR_W-1:0] awaddr,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [upd_periph_pkg::AXI_DATA_W-1:0] wdata,
  input  logic [upd_periph_pkg::AXI_DATA_W/8-1:0] wstrb,
  input  logic                                wvalid,
  output logic                                wready,
  output logic                                bvalid,
  output logic [1:0]                          bresp,
  input  logic                                bready,
  input  logic [upd_periph_pkg::AXI_ADDR_W-1:0] araddr,
  input  logic                                arvalid,
  output logic                                arready,
  output logic                                rvalid,
  output logic [upd_periph_pkg::AXI_DATA_W-1:0] rdata,
  output logic [1:0]                          rresp,
  input  logic                                rready,
  output logic [upd_periph_pkg::SFR_W-1:0]    sfr_wdata,
  output logic                                wr_pa,
  output logic                                wr_pb,
  output logic                                wr_pc,
  output logic                                wr_mk,
  output logic                                wr_mb,
  output logic                                wr_mc,
  output logic                                wr_tm0,
  output logic                                wr_tm1,
  output logic                                wr_ie,
  output logic                                wr_stm,
  output logic                                wr_iack,
  input  logic [upd_periph_pkg::SFR_W-1:0]    pa_q,
  input  logic [upd_periph_pkg::SFR_W-1:0]    pb_rd,
  input  logic [upd_periph_pkg::SFR_W-1:0]    pc_rd,
  input  logic [upd_periph_pkg::SFR_W-1:0]    mk_q,
  input  logic [upd_periph_pkg::SFR_W-1:0]    mb_q,
  input  logic [upd_periph_pkg::SFR_W-1:0]    mc_q,
  input  logic [upd_periph_pkg::TM_W-1:0]     tm_q,
  input  logic                                ie_q,
  input  logic [upd_periph_pkg::SFR_W-1:0]    vector
);
  import upd_periph_pkg::*;

  logic             aw_hs;
  logic             ar_hs;
  logic [SFR_W-1:0] rd_byte;

  function automatic logic sfr_mapped(input logic [AXI_ADDR_W-1:0] addr);
    case (addr)
      SFR_PA, SFR_PB, SFR_PC, SFR_MK, SFR_MB, SFR_MC,
      SFR_TM0, SFR_TM1, SFR_IE, SFR_STM, SFR_IACK: sfr_mapped = 1'b1;
      default: sfr_mapped = 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////
  // Write channel

  // Address and data are taken together, one write in flight
  always_ff @(posedge CLK) begin
    if (reset) begin
      aw_hs  <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      aw_hs <= awvalid & wvalid & ~bvalid & ~aw_hs;
      if (aw_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (aw_hs) begin
      bresp <= sfr_mapped(awaddr) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
  end

  assign awready   = aw_hs;
  assign wready    = aw_hs;
  assign sfr_wdata = wdata[SFR_W-1:0];

  // Strobes live only for the handshake cycle
  assign wr_pa   = aw_hs & (awaddr == SFR_PA);
  assign wr_pb   = aw_hs & (awaddr == SFR_PB);
  assign wr_pc   = aw_hs & (awaddr == SFR_PC);
  assign wr_mk   = aw_hs & (awaddr == SFR_MK);
  assign wr_mb   = aw_hs & (awaddr == SFR_MB);
  assign wr_mc   = aw_hs & (awaddr == SFR_MC);
  assign wr_tm0  = aw_hs & (awaddr == SFR_TM0);
  assign wr_tm1  = aw_hs & (awaddr == SFR_TM1);
  assign wr_ie   = aw_hs & (awaddr == SFR_IE);
  assign wr_stm  = aw_hs & (awaddr == SFR_STM);
  assign wr_iack = aw_hs & (awaddr == SFR_IACK);

  ////////////////////////////////////////
  // Read channel

  always_comb begin
    case (araddr)
      SFR_PA:   rd_byte = pa_q;
      SFR_PB:   rd_byte = pb_rd;
      SFR_PC:   rd_byte = pc_rd;
      SFR_MK:   rd_byte = mk_q;
      SFR_MB:   rd_byte = mb_q;
      SFR_MC:   rd_byte = mc_q;
      SFR_TM0:  rd_byte = tm_q[SFR_W-1:0];
      // Upper nibble of TM, zero extended
      SFR_TM1:  rd_byte = {{(2*SFR_W-TM_W){1'b0}}, tm_q[TM_W-1:SFR_W]};
      SFR_IE:   rd_byte = {{(SFR_W-1){1'b0}}, ie_q};
      SFR_IACK: rd_byte = vector;
      default:  rd_byte = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      ar_hs  <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      ar_hs <= arvalid & ~rvalid & ~ar_hs;
      if (ar_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Data captured in the arready cycle
  always_ff @(posedge CLK) begin
    if (ar_hs) begin
      rdata <= {{(AXI_DATA_W-SFR_W){1'b0}}, rd_byte};
      rresp <= sfr_mapped(araddr) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
  end

  assign arready = ar_hs;

endmodule

// ==== rtl/upd_timer.sv ====
module upd_timer (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic [upd_periph_pkg::SFR_W-1:0] sfr_wdata,
  input  logic                             wr_tm0,
  input  logic                             wr_tm1,
  input  logic                             wr_stm,
  output logic [upd_periph_pkg::TM_W-1:0]  tm_q,
  output logic                             tc_uf
);
  import upd_periph_pkg::*;

  logic [TM_W-1:0]            tm;
  // Low bits are the divide-by-8 prescaler
  logic [TM_W+PRESCALE_W-1:0] tc;

  ////////////////////////////////////////
  // Reload value

  always_ff @(posedge CLK) begin
    if (reset) begin
      tm <= TM_RESET;
    end else begin
      if (wr_tm0) tm[SFR_W-1:0] <= sfr_wdata;
      if (wr_tm1) tm[TM_W-1:SFR_W] <= sfr_wdata[TM_W-SFR_W-1:0];
    end
  end

  ////////////////////////////////////////
  // Down counter

  assign tc_uf = ~|tc;

  // Reload on underflow or STM, prescaler restarts at 7
  always_ff @(posedge CLK) begin
    if (reset) begin
      tc <= '1;
    end else if (tc_uf | wr_stm) begin
      tc <= {tm, {PRESCALE_W{1'b1}}};
    end else begin
      tc <= tc - 1'b1;
    end
  end

  assign tm_q = tm;

endmodule

// ==== sim/upd_periph_props.sv ====
module upd_periph_props (
  input logic                                  CLK,
  input logic                                  reset,
  input logic                                  awready, wready, arready, bvalid, rvalid,
  input logic                                  awvalid, wvalid, arvalid, bready, rready,
  input logic [upd_periph_pkg::AXI_ADDR_W-1:0] awaddr, araddr,
  input logic [1:0]                            bresp, rresp,
  input logic [upd_periph_pkg::AXI_DATA_W-1:0] rdata,
  input logic [upd_periph_pkg::SFR_W-1:0]      pb_i, pc_i, pa_o, pb_o, pb_oe, pc_o, pc_oe,
  input logic [upd_periph_pkg::SFR_W-1:0]      sfr_wdata, mk_q, mc_q, vector, pc_latch,
  input logic                                  wr_pa, wr_pb, wr_mb, wr_stm, wr_iack,
  input logic                                  int1, int2, irq, tc_uf, ie_q,
  input logic [upd_periph_pkg::TM_W-1:0]       tm_q,
  input logic [upd_periph_pkg::N_IRQ-1:0]      pend
);
  import upd_periph_pkg::*;

  int               fails = 0;
  int               uf_cnt;
  int               uf_exp;
  logic             uf_armed;
  logic [N_IRQ-1:0] en;
  logic [N_IRQ-1:0] top;
  logic [SFR_W-1:0] exp_vec;
  logic             int2_eff;

  task automatic count_fail(input string msg);
    $error("%s", msg);
    fails++;
  endtask

  function automatic logic is_mapped(input logic [AXI_ADDR_W-1:0] addr);
    return (addr[1:0] == 2'b00) && (addr <= SFR_IACK);
  endfunction

  ////////////////////////////////////////
  // Reference state

  assign en       = pend & ~mk_q[N_IRQ-1:0] & {N_IRQ{ie_q}};
  assign int2_eff = mk_q[MK_INT2_POL] ? int2 : ~int2;

  // Fixed priority, INT0 first
  always_comb begin
    top = '0;
    exp_vec = VEC_NONE;
    if (en[II_INT0]) begin
      top[II_INT0] = 1'b1;
      exp_vec = VEC_INT0;
    end else if (en[II_INTT]) begin
      top[II_INTT] = 1'b1;
      exp_vec = VEC_INTT;
    end else if (en[II_INT1]) begin
      top[II_INT1] = 1'b1;
      exp_vec = VEC_INT1;
    end else if (en[II_INT2]) begin
      top[II_INT2] = 1'b1;
      exp_vec = VEC_INT2;
    end
  end

  // Cycles since the last STM or underflow
  always_ff @(posedge CLK) begin
    if (reset) begin
      uf_cnt   <= 0;
      uf_exp   <= 0;
      uf_armed <= 1'b0;
    end else if (wr_stm || tc_uf) begin
      uf_cnt   <= 1;
      uf_exp   <= tm_q * 8 + 8;
      uf_armed <= uf_armed | wr_stm;
    end else begin
      uf_cnt <= uf_cnt + 1;
    end
  end

  ////////////////////////////////////////
  // Reset and ports

  a_reset: assert property (@(posedge CLK) $fell(reset) |->
    !awready && !wready && !arready && !bvalid && !rvalid && !irq && pb_oe == 8'h00)
    else count_fail("Outputs not idle after reset");
  a_pa: assert property (@(posedge CLK) disable iff (reset) wr_pa |=> pa_o == $past(sfr_wdata))
    else count_fail("Port A output does not follow write");
  a_pb: assert property (@(posedge CLK) disable iff (reset) wr_pb |=> pb_o == $past(sfr_wdata))
    else count_fail("Port B output does not follow write");
  a_mb: assert property (@(posedge CLK) disable iff (reset)
    wr_mb |=> pb_oe == ~$past(sfr_wdata))
    else count_fail("Port B enable is not the inverse of MB");
  a_pc_oe: assert property (@(posedge CLK) disable iff (reset)
    pc_oe == (PC_FIXED_OE | (~mc_q & 8'h83)))
    else count_fail("Port C enable breaks the MC rule");
  a_pc_o: assert property (@(posedge CLK) disable iff (reset)
    pc_o == (pc_latch & ((mc_q & 8'hFC) | (~mc_q & 8'h03))))
    else count_fail("Port C output breaks the MC mask rule");
  a_rd_pb: assert property (@(posedge CLK) disable iff (reset) arready && araddr == SFR_PB
    |=> rdata[7:0] == $past((pb_o & pb_oe) | (pb_i & ~pb_oe)))
    else count_fail("Port B read-back mixes pins and latch wrongly");
  a_rd_pc: assert property (@(posedge CLK) disable iff (reset) arready && araddr == SFR_PC
    |=> rdata[7:0] == $past((pc_latch & pc_oe) | (pc_i & ~pc_oe)))
    else count_fail("Port C read-back mixes pins and latch wrongly");

  ////////////////////////////////////////
  // Timer and interrupts

  a_uf: assert property (@(posedge CLK) disable iff (reset)
    tc_uf && uf_armed |-> uf_cnt == uf_exp)
    else count_fail("Timer underflow came at the wrong cycle");
  a_uf_irq: assert property (@(posedge CLK) disable iff (reset)
    tc_uf && ie_q && !mk_q[II_INTT] |=> irq)
    else count_fail("Timer underflow did not raise the interrupt");
  a_int1: assert property (@(posedge CLK) disable iff (reset) $rose(pend[II_INT1]) |->
    $past(int1, 2) && $past(int1, 3) && $past(int1, 4) && !$past(int1, 5))
    else count_fail("INT1 pending without low then three high samples");
  a_int2: assert property (@(posedge CLK) disable iff (reset) $rose(pend[II_INT2]) |->
    $past(int2_eff, 2) && $past(int2_eff, 3) && $past(int2_eff, 4) && !$past(int2_eff, 5))
    else count_fail("INT2 pending without a filtered edge");
  a_vec: assert property (@(posedge CLK) disable iff (reset) vector == exp_vec)
    else count_fail("Vector does not match the priority winner");
  a_irq: assert property (@(posedge CLK) disable iff (reset) irq == |en)
    else count_fail("Interrupt line does not match enabled requests");
  a_ack: assert property (@(posedge CLK) disable iff (reset) wr_iack |=>
    ($past(pend[N_IRQ-1:1]) & ~$past(top[N_IRQ-1:1]) & ~pend[N_IRQ-1:1]) == '0 &&
    (pend[N_IRQ-1:1] & $past(top[N_IRQ-1:1])) == '0)
    else count_fail("Acknowledge cleared the wrong request");

  ////////////////////////////////////////
  // Bus responses

  a_aw: assert property (@(posedge CLK) disable iff (reset)
    awready || wready |-> awready && wready && awvalid && wvalid && !bvalid)
    else count_fail("Write accepted without address and data");
  a_ar: assert property (@(posedge CLK) disable iff (reset) arready |-> arvalid && !rvalid)
    else count_fail("Read accepted without an address");
  a_bhold: assert property (@(posedge CLK) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else count_fail("Write response changed under back-pressure");
  a_rhold: assert property (@(posedge CLK) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else count_fail("Read response changed under back-pressure");
  a_wslv: assert property (@(posedge CLK) disable iff (reset)
    awready && !is_mapped(awaddr) |=> bresp == AXI_RESP_SLVERR)
    else count_fail("Unmapped write did not answer SLVERR");
  a_rslv: assert property (@(posedge CLK) disable iff (reset)
    arready && !is_mapped(araddr) |=> rresp == AXI_RESP_SLVERR && rdata == '0)
    else count_fail("Unmapped read did not answer SLVERR with zero data");

endmodule

bind upd_periph upd_periph_props upd_periph_props_i (
  .*,
  .pc_latch(upd_ports_i.pco),
  .pend(upd_intc_i.pend)
);

// ==== sim/upd_periph_tb.sv ====
module upd_periph_tb;
  import upd_periph_pkg::*;

  logic                  CLK, reset;
  logic [AXI_ADDR_W-1:0] awaddr, araddr;
  logic                  awvalid, wvalid, bready, arvalid, rready;
  logic [AXI_DATA_W-1:0] wdata, rdata;
  logic [3:0]            wstrb;
  logic                  awready, wready, bvalid, arready, rvalid, irq;
  logic [1:0]            bresp, rresp;
  logic [SFR_W-1:0]      pb_i, pc_i, pa_o, pb_o, pb_oe, pc_o, pc_oe;
  logic                  int0, int1, int2;

  int               read_errs = 0;
  int               fails_mark = 0;
  int               errs_mark = 0;
  int               tests_pass = 0;
  int               tests_fail = 0;
  logic [SFR_W-1:0] rd_byte;
  logic [1:0]       rd_resp;
  logic [1:0]       wr_resp;
  logic [SFR_W-1:0] tm_val;

  upd_periph upd_periph_i (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation failed");
    $finish;
  endtask

  // Waits at the falling edge, where outputs are settled
  task automatic wait_for(input string what, input int limit, ref logic sig, input logic lvl);
    int n;
    n = 0;
    @(negedge CLK);
    while (sig !== lvl) begin
      n++;
      if (n > limit) stop_on_timeout(what);
      @(negedge CLK);
    end
  endtask

  task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [SFR_W-1:0] data);
    int n;
    @(posedge CLK);
    awaddr  <= addr;
    wdata   <= {24'h0, data};
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    wait_for("write handshake", 50, awready, 1'b1);
    @(posedge CLK);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n = 0;
    @(negedge CLK);
    while (!(bvalid && bready)) begin
      n++;
      if (n > 50) stop_on_timeout("write response");
      @(negedge CLK);
    end
    wr_resp = bresp;
  endtask

  task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr);
    int n;
    @(posedge CLK);
    araddr  <= addr;
    arvalid <= 1'b1;
    wait_for("read handshake", 50, arready, 1'b1);
    @(posedge CLK);
    arvalid <= 1'b0;
    n = 0;
    @(negedge CLK);
    while (!(rvalid && rready)) begin
      n++;
      if (n > 50) stop_on_timeout("read response");
      @(negedge CLK);
    end
    rd_byte = rdata[SFR_W-1:0];
    rd_resp = rresp;
  endtask

  task automatic check_value(input string name, input logic [SFR_W-1:0] exp,
                             input logic [SFR_W-1:0] act);
    if (act !== exp) begin
      $display("Error: %s expected 0x%02h actual 0x%02h", name, exp, act);
      read_errs++;
    end
  endtask

  task automatic check_read(input string name, input logic [AXI_ADDR_W-1:0] addr,
                            input logic [SFR_W-1:0] exp);
    axi_read(addr);
    check_value(name, exp, rd_byte);
  endtask

  // Active level for width cycles on INT1 (which = 1) or INT2
  task automatic pulse_int(input int which, input int width, input logic active);
    @(posedge CLK);
    if (which == 1) int1 <= active;
    else int2 <= active;
    repeat (width) @(posedge CLK);
    if (which == 1) int1 <= ~active;
    else int2 <= ~active;
  endtask

  task automatic end_test(input string name);
    int bad;
    bad = (upd_periph_i.upd_periph_props_i.fails - fails_mark) + (read_errs - errs_mark);
    if (bad == 0) begin
      tests_pass++;
      $display("Test %s: passed", name);
    end else begin
      tests_fail++;
      $display("Test %s: failed with %0d errors", name, bad);
    end
    fails_mark = upd_periph_i.upd_periph_props_i.fails;
    errs_mark  = read_errs;
  endtask

  initial begin
    void'($urandom(51067));
    reset   = 1'b1;
    awaddr  = '0;
    araddr  = '0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    wdata   = '0;
    wstrb   = 4'hF;
    bready  = 1'b1;
    rready  = 1'b1;
    pb_i    = '0;
    pc_i    = '0;
    int0    = 1'b0;
    int1    = 1'b0;
    // INT2 idles high
    int2    = 1'b1;
    repeat (10) @(posedge CLK);
    reset <= 1'b0;

    //////////////////////////////////////// Reset state and port writes
    axi_write(SFR_PA, 8'($urandom));
    axi_write(SFR_PB, 8'($urandom));
    axi_write(SFR_MB, 8'($urandom));
    axi_write(SFR_MC, 8'($urandom));
    axi_write(SFR_PC, 8'($urandom));
    end_test("reset_and_ports");

    //////////////////////////////////////// Port read-back
    repeat (4) begin
      @(posedge CLK);
      pb_i <= 8'($urandom);
      pc_i <= 8'($urandom);
      axi_write(SFR_MB, 8'($urandom));
      axi_write(SFR_MC, 8'($urandom));
      axi_write(SFR_PB, 8'($urandom));
      axi_write(SFR_PC, 8'($urandom));
      axi_read(SFR_PB);
      axi_read(SFR_PC);
    end
    end_test("port_readback");

    //////////////////////////////////////// Timer
    tm_val = 8'($urandom_range(20, 2));
    axi_write(SFR_TM0, tm_val);
    axi_write(SFR_TM1, 8'h00);
    check_read("tm0_readback", SFR_TM0, tm_val);
    axi_write(SFR_IE, 8'h01);
    axi_write(SFR_MK, 8'hFD);
    axi_write(SFR_STM, 8'h00);
    wait_for("timer interrupt", 400, irq, 1'b1);
    check_read("timer_vector", SFR_IACK, VEC_INTT);
    axi_write(SFR_MK, 8'hFF);
    end_test("timer_underflow");

    //////////////////////////////////////// Edge filter
    axi_write(SFR_MK, 8'hFB);
    pulse_int(1, 2, 1'b1);
    repeat (8) @(posedge CLK);
    check_read("int1_short_pulse", SFR_IACK, VEC_NONE);
    pulse_int(1, 4, 1'b1);
    wait_for("INT1 interrupt", 50, irq, 1'b1);
    check_read("int1_vector", SFR_IACK, VEC_INT1);
    axi_write(SFR_IACK, 8'h00);
    wait_for("INT1 acknowledge", 50, irq, 1'b0);
    // INT2 active low from here on
    axi_write(SFR_MK, 8'hD7);
    pulse_int(2, 4, 1'b0);
    wait_for("INT2 interrupt", 50, irq, 1'b1);
    check_read("int2_vector", SFR_IACK, VEC_INT2);
    axi_write(SFR_IACK, 8'h00);
    wait_for("INT2 acknowledge", 50, irq, 1'b0);
    end_test("edge_filter");

    //////////////////////////////////////// Priority and acknowledge
    axi_write(SFR_MK, 8'hD2);
    @(posedge CLK);
    int0 <= 1'b1;
    pulse_int(1, 4, 1'b1);
    pulse_int(2, 4, 1'b0);
    repeat (6) @(posedge CLK);
    check_read("prio_int0", SFR_IACK, VEC_INT0);
    axi_write(SFR_IACK, 8'h00);
    check_read("prio_int0_level", SFR_IACK, VEC_INT0);
    @(posedge CLK);
    int0 <= 1'b0;
    check_read("prio_int1", SFR_IACK, VEC_INT1);
    axi_write(SFR_IACK, 8'h00);
    check_read("prio_int2", SFR_IACK, VEC_INT2);
    axi_write(SFR_IACK, 8'h00);
    check_read("prio_none", SFR_IACK, VEC_NONE);
    wait_for("interrupt release", 50, irq, 1'b0);
    axi_write(SFR_MK, 8'hFF);
    end_test("priority_ack");

    //////////////////////////////////////// Unmapped and back-pressure
    @(posedge CLK);
    bready <= 1'b0;
    fork
      axi_write(6'h3C, 8'h55);
      begin
        repeat (8) @(posedge CLK);
        bready <= 1'b1;
      end
    join
    check_value("unmapped_bresp", 8'(AXI_RESP_SLVERR), 8'(wr_resp));
    @(posedge CLK);
    rready <= 1'b0;
    fork
      axi_read(6'h2C);
      begin
        repeat (8) @(posedge CLK);
        rready <= 1'b1;
      end
    join
    check_value("unmapped_rresp", 8'(AXI_RESP_SLVERR), 8'(rd_resp));
    check_value("unmapped_rdata", 8'h00, rd_byte);
    end_test("unmapped_backpressure");

    repeat (2) @(posedge CLK);
    $display("Tests passed: %0d, failed: %0d", tests_pass, tests_fail);
    if (tests_fail == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
